// File: tpu_pkg.sv
package tpu_pkg;

    // array and element sizes
    localparam int MUL_SIZE = 8;
    localparam int DATA_W   = 8;
    localparam int ACC_W    = 20;

    localparam int IQ_DEPTH = 4;
    localparam int WF_DEPTH = 8;

    localparam int ROW_W    = $clog2(MUL_SIZE);
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int WF_PTR_W = $clog2(WF_DEPTH);

    typedef logic signed [DATA_W-1:0] elem_t;
    typedef elem_t [MUL_SIZE-1:0]     vec_t;     // weight row or activation vector
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [MUL_SIZE-1:0]      row_mask_t;

    typedef logic [7:0]       dim_t;
    typedef logic [5:0]       tile_idx_t;
    typedef logic [7:0]       vcnt_t;            // activation vectors per tile
    typedef logic [15:0]      tile_cnt_t;
    typedef logic [ROW_W-1:0] row_idx_t;

    typedef struct packed {
        logic [1:0] mac_op;       // bit 1 set means load weights
        dim_t       u_dim;
        dim_t       iter_dim;
        vcnt_t      vec_count;
    } decoded_instr_t;

    typedef struct packed {
        tile_idx_t           tile;
        acc_t [MUL_SIZE-1:0] sums;
    } result_t;

endpackage

// File: instr_queue.sv
`timescale 1ns/1ps

module instr_queue (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    push_i,
    input  tpu_pkg::decoded_instr_t instr_i,
    input  logic                    pop_i,
    output tpu_pkg::decoded_instr_t instr_o,
    output logic                    empty_o,
    output logic                    full_o
);

    tpu_pkg::decoded_instr_t mem_q [tpu_pkg::IQ_DEPTH];

    logic [tpu_pkg::IQ_PTR_W-1:0] wr_ptr_q;
    logic [tpu_pkg::IQ_PTR_W-1:0] rd_ptr_q;
    logic [tpu_pkg::IQ_PTR_W:0]   count_q;
    logic                         do_push;
    logic                         do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (tpu_pkg::IQ_PTR_W + 1)'(tpu_pkg::IQ_DEPTH));
    assign do_push = push_i && !full_o;   // push into a full queue is lost
    assign do_pop  = pop_i && !empty_o;
    assign instr_o = mem_q[rd_ptr_q];     // head shown ahead of the pop

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_o))
        else $error("instr_queue: push while full, instruction dropped");

endmodule

// File: weight_fifo.sv
`timescale 1ns/1ps

module weight_fifo (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          push_i,
    input  tpu_pkg::vec_t row_i,
    input  logic          pop_i,
    output tpu_pkg::vec_t row_o,
    output logic          valid_o,
    output logic          full_o
);

    tpu_pkg::vec_t mem_q [tpu_pkg::WF_DEPTH];

    logic [tpu_pkg::WF_PTR_W-1:0] wr_ptr_q;
    logic [tpu_pkg::WF_PTR_W-1:0] rd_ptr_q;
    logic [tpu_pkg::WF_PTR_W:0]   count_q;
    logic                         do_push;
    logic                         do_pop;

    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == (tpu_pkg::WF_PTR_W + 1)'(tpu_pkg::WF_DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    // head row goes to every processing row at once
    assign row_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= row_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // the control unit must only load rows that are there
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && !valid_o))
        else $error("weight_fifo: pop without a valid row");

endmodule

// File: weight_control_unit.sv
`timescale 1ns/1ps

module weight_control_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  tpu_pkg::decoded_instr_t instr_i,
    input  logic                    iq_empty_i,
    input  logic                    wf_valid_i,
    input  logic                    next_weight_tile_i,
    output logic                    read_instruction_o,
    output logic                    wf_pop_o,
    output tpu_pkg::row_mask_t      load_weights_o,
    output logic                    swap_tile_o,
    output logic                    compute_rdy_o,
    output logic                    weights_buffered_o,
    output tpu_pkg::tile_idx_t      tile_o,
    output tpu_pkg::vcnt_t          vec_count_o
);

    typedef enum logic [1:0] {
        RESET,
        LOAD_WEIGHTS,
        DOUBLE_BUFFER,
        FULL
    } state_e;

    state_e             state_q;
    tpu_pkg::row_idx_t  row_cnt_q;
    logic               shadow_full_q;
    logic               swap_pending_q;   // swap asked for before the shadow bank filled
    logic               load_done_q;      // every tile of the instruction is loaded
    tpu_pkg::row_mask_t loaded_mask_q;
    tpu_pkg::tile_idx_t load_tile_q;

    tpu_pkg::tile_cnt_t tile_total_q;
    tpu_pkg::vcnt_t     load_vcnt_q;
    tpu_pkg::tile_idx_t shadow_tile_q;
    tpu_pkg::vcnt_t     shadow_vcnt_q;
    tpu_pkg::tile_idx_t tile_q;
    tpu_pkg::vcnt_t     vcnt_q;

    logic computing;
    logic loading;
    logic last_row;
    logic tile_last;
    logic drain;
    logic take_instr;
    logic swap_req;

    assign computing = (state_q == DOUBLE_BUFFER) || (state_q == FULL);
    assign loading   = ((state_q == LOAD_WEIGHTS) || (state_q == DOUBLE_BUFFER))
                       && !shadow_full_q && !load_done_q && wf_valid_i;
    assign last_row  = loading && (row_cnt_q == tpu_pkg::ROW_W'(tpu_pkg::MUL_SIZE - 1));
    assign tile_last = (tpu_pkg::tile_cnt_t'(load_tile_q) + 1'b1) >= tile_total_q;
    assign drain     = (state_q == DOUBLE_BUFFER) && load_done_q;

    // pop when idle or once the last tile of the running instruction is active
    assign read_instruction_o = !iq_empty_i && ((state_q == RESET) || drain);
    assign take_instr         = read_instruction_o && instr_i.mac_op[1];

    assign swap_req    = next_weight_tile_i || swap_pending_q;
    assign swap_tile_o = shadow_full_q
                         && ((state_q == LOAD_WEIGHTS) || ((state_q == FULL) && swap_req));

    assign load_weights_o = loading ? tpu_pkg::row_mask_t'(1) << row_cnt_q : '0;
    assign wf_pop_o       = loading;

    assign compute_rdy_o      = computing && !swap_pending_q && !next_weight_tile_i;
    assign weights_buffered_o = (state_q == FULL);
    assign tile_o             = tile_q;
    assign vec_count_o        = vcnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q        <= RESET;
            row_cnt_q      <= '0;
            shadow_full_q  <= 1'b0;
            swap_pending_q <= 1'b0;
            load_done_q    <= 1'b0;
            loaded_mask_q  <= '0;
            load_tile_q    <= '0;
        end else begin
            if (take_instr) begin
                load_tile_q <= '0;   // tile numbering restarts per instruction
                load_done_q <= 1'b0;
            end
            if (loading) begin
                row_cnt_q <= last_row ? '0 : row_cnt_q + 1'b1;
            end
            if (last_row) begin
                shadow_full_q <= 1'b1;
                load_tile_q   <= load_tile_q + 1'b1;
                load_done_q   <= tile_last;
            end

            if (swap_tile_o) begin
                shadow_full_q  <= 1'b0;
                loaded_mask_q  <= '0;
                swap_pending_q <= 1'b0;
            end else begin
                loaded_mask_q <= loaded_mask_q | load_weights_o;
                if (next_weight_tile_i && computing) begin
                    swap_pending_q <= 1'b1;
                end
            end

            case (state_q)
                RESET: begin
                    if (take_instr) begin
                        state_q <= LOAD_WEIGHTS;
                    end
                end
                LOAD_WEIGHTS: begin
                    if (swap_tile_o) begin
                        state_q <= DOUBLE_BUFFER;
                    end
                end
                DOUBLE_BUFFER: begin
                    if (last_row) begin
                        state_q <= FULL;
                    end else if (swap_req && load_done_q && !take_instr) begin
                        state_q        <= RESET;   // nothing left to swap in
                        swap_pending_q <= 1'b0;
                    end
                end
                FULL: begin
                    if (swap_tile_o) begin
                        state_q <= DOUBLE_BUFFER;
                    end
                end
                default: state_q <= RESET;
            endcase
        end
    end

    // tags and counts follow the tile from shadow to active bank
    always_ff @(posedge clk_i) begin
        if (take_instr) begin
            tile_total_q <= tpu_pkg::tile_cnt_t'(instr_i.u_dim / tpu_pkg::MUL_SIZE)
                            * tpu_pkg::tile_cnt_t'(instr_i.iter_dim / tpu_pkg::MUL_SIZE);
            load_vcnt_q  <= instr_i.vec_count;
        end
        if (last_row) begin
            shadow_tile_q <= load_tile_q;
            shadow_vcnt_q <= load_vcnt_q;
        end
        if (swap_tile_o) begin
            tile_q <= shadow_tile_q;
            vcnt_q <= shadow_vcnt_q;
        end
    end

    // a row is written at most once per tile
    a_load_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(load_weights_o) && !(|(load_weights_o & loaded_mask_q)))
        else $error("weight_control_unit: load_weights_o not one-hot or row written twice");

    // every row must have been written since the previous swap
    a_swap_full: assert property (@(posedge clk_i) disable iff (rst_i)
        swap_tile_o |-> (&loaded_mask_q))
        else $error("weight_control_unit: swap with a partly loaded shadow bank");

endmodule

// File: pe_row.sv
`timescale 1ns/1ps

module pe_row (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          load_i,
    input  logic          swap_i,
    input  tpu_pkg::vec_t row_i,
    input  logic          act_valid_i,
    input  tpu_pkg::vec_t act_i,
    output tpu_pkg::acc_t sum_o
);

    tpu_pkg::vec_t shadow_q;   // next tile's row
    tpu_pkg::vec_t active_q;   // row in use
    tpu_pkg::acc_t dot;

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            shadow_q <= row_i;
        end
        if (swap_i) begin
            active_q <= shadow_q;
        end
    end

    // signed multiply-accumulate across the row
    always_comb begin
        dot = '0;
        for (int i = 0; i < tpu_pkg::MUL_SIZE; i++) begin
            dot = dot + $signed(active_q[i]) * $signed(act_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_o <= '0;
        end else if (act_valid_i) begin
            sum_o <= dot;   // one cycle after acceptance
        end
    end

endmodule

// File: result_collector.sv
`timescale 1ns/1ps

module result_collector (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 act_accept_i,
    input  tpu_pkg::acc_t [tpu_pkg::MUL_SIZE-1:0] sums_i,
    input  tpu_pkg::tile_idx_t                   tile_i,
    input  tpu_pkg::vcnt_t                       vec_count_i,
    output logic                                 next_weight_tile_o,
    output logic                                 res_valid_o,
    output tpu_pkg::result_t                     res_o
);

    logic               accept_d_q;   // lines up with the row sums
    tpu_pkg::tile_idx_t tile_d_q;
    tpu_pkg::vcnt_t     vec_cnt_q;

    always_ff @(posedge clk_i) begin
        tile_d_q <= tile_i;
        if (accept_d_q) begin
            res_o.tile <= tile_d_q;
            res_o.sums <= sums_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            accept_d_q  <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            accept_d_q  <= act_accept_i;
            res_valid_o <= accept_d_q;
        end
    end

    // vectors seen on the active tile
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vec_cnt_q          <= '0;
            next_weight_tile_o <= 1'b0;
        end else begin
            next_weight_tile_o <= 1'b0;
            if (act_accept_i) begin
                if (vec_cnt_q + 1'b1 == vec_count_i) begin
                    vec_cnt_q          <= '0;
                    next_weight_tile_o <= 1'b1;   // tile used up
                end else begin
                    vec_cnt_q <= vec_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

// File: tpu_weight_top.sv
`timescale 1ns/1ps

module tpu_weight_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    instr_push_i,
    input  tpu_pkg::decoded_instr_t instr_i,
    output logic                    instr_full_o,
    input  logic                    weight_push_i,
    input  tpu_pkg::vec_t           weight_row_i,
    output logic                    weight_full_o,
    input  logic                    act_valid_i,
    input  tpu_pkg::vec_t           act_i,
    output logic                    compute_rdy_o,
    output logic                    weights_buffered_o,
    output logic                    res_valid_o,
    output tpu_pkg::result_t        res_o
);

    tpu_pkg::decoded_instr_t              iq_head;
    logic                                 iq_empty;
    logic                                 read_instruction;
    tpu_pkg::vec_t                        wf_head;
    logic                                 wf_valid;
    logic                                 wf_pop;
    tpu_pkg::row_mask_t                   load_weights;
    logic                                 swap_tile;
    logic                                 next_weight_tile;
    tpu_pkg::tile_idx_t                   tile;
    tpu_pkg::vcnt_t                       vec_count;
    logic                                 act_accept;
    tpu_pkg::acc_t [tpu_pkg::MUL_SIZE-1:0] row_sums;

    assign act_accept = act_valid_i && compute_rdy_o;

    instr_queue iq0 (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (instr_push_i),
        .instr_i (instr_i),
        .pop_i   (read_instruction),
        .instr_o (iq_head),
        .empty_o (iq_empty),
        .full_o  (instr_full_o)
    );

    weight_fifo wf0 (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (weight_push_i),
        .row_i   (weight_row_i),
        .pop_i   (wf_pop),
        .row_o   (wf_head),
        .valid_o (wf_valid),
        .full_o  (weight_full_o)
    );

    weight_control_unit wcu0 (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .instr_i            (iq_head),
        .iq_empty_i         (iq_empty),
        .wf_valid_i         (wf_valid),
        .next_weight_tile_i (next_weight_tile),
        .read_instruction_o (read_instruction),
        .wf_pop_o           (wf_pop),
        .load_weights_o     (load_weights),
        .swap_tile_o        (swap_tile),
        .compute_rdy_o      (compute_rdy_o),
        .weights_buffered_o (weights_buffered_o),
        .tile_o             (tile),
        .vec_count_o        (vec_count)
    );

    for (genvar k = 0; k < tpu_pkg::MUL_SIZE; k++) begin : g_row
        pe_row row0 (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .load_i      (load_weights[k]),
            .swap_i      (swap_tile),
            .row_i       (wf_head),
            .act_valid_i (act_accept),
            .act_i       (act_i),
            .sum_o       (row_sums[k])
        );
    end

    result_collector rc0 (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .act_accept_i       (act_accept),
        .sums_i             (row_sums),
        .tile_i             (tile),
        .vec_count_i        (vec_count),
        .next_weight_tile_o (next_weight_tile),
        .res_valid_o        (res_valid_o),
        .res_o              (res_o)
    );

endmodule

// File: tb_tpu_weight.sv
`timescale 1ns/1ps

module tb_tpu_weight;

    typedef tpu_pkg::vec_t [tpu_pkg::MUL_SIZE-1:0] tile_t;   // row k feeds pe_row k

    localparam int TOTAL_ROWS = 80;
    localparam int TOTAL_VECS = 64;
    localparam int MAX_CYCLES = (TOTAL_ROWS + TOTAL_VECS) * 4 + 200;

    logic                    clk_i;
    logic                    rst_i;
    logic                    instr_push_i;
    tpu_pkg::decoded_instr_t instr_i;
    logic                    instr_full_o;
    logic                    weight_push_i;
    tpu_pkg::vec_t           weight_row_i;
    logic                    weight_full_o;
    logic                    act_valid_i;
    tpu_pkg::vec_t           act_i;
    logic                    compute_rdy_o;
    logic                    weights_buffered_o;
    logic                    res_valid_o;
    tpu_pkg::result_t        res_o;

    tile_t wt [16];
    int    ins_vcnt [8];
    int    ins_tiles [8];
    int    ins_base [8];
    int    ins_n;
    int    cur_ins;      // instruction owning the next accepted vector
    int    cur_acc;

    tpu_pkg::result_t exp_q [$];
    int               acc_cyc_q [$];

    logic [31:0] rng_state;
    int          cycle = 0;
    int          checks;
    int          errors;
    int          rows_pushed;
    int          idle_entries;
    logic        idle_d;
    logic        saw_buffered;

    tpu_weight_top dut0 (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .instr_push_i       (instr_push_i),
        .instr_i            (instr_i),
        .instr_full_o       (instr_full_o),
        .weight_push_i      (weight_push_i),
        .weight_row_i       (weight_row_i),
        .weight_full_o      (weight_full_o),
        .act_valid_i        (act_valid_i),
        .act_i              (act_i),
        .compute_rdy_o      (compute_rdy_o),
        .weights_buffered_o (weights_buffered_o),
        .res_valid_o        (res_valid_o),
        .res_o              (res_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic tpu_pkg::vec_t rand_vec();
        tpu_pkg::vec_t v;
        for (int i = 0; i < tpu_pkg::MUL_SIZE; i++) begin
            rng_state = xorshift32(rng_state);
            v[i] = rng_state[7:0];
        end
        return v;
    endfunction

    // expected result holds one signed dot product per weight row
    function automatic tpu_pkg::result_t ref_result(input tpu_pkg::tile_idx_t t,
                                                    input tile_t w, input tpu_pkg::vec_t a);
        tpu_pkg::result_t r;
        int               acc;
        r.tile = t;
        for (int k = 0; k < tpu_pkg::MUL_SIZE; k++) begin
            acc = 0;
            for (int i = 0; i < tpu_pkg::MUL_SIZE; i++) begin
                acc = acc + $signed(w[k][i]) * $signed(a[i]);
            end
            r.sums[k] = tpu_pkg::acc_t'(acc);
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fill_tiles(input int first_slot, input int count);
        for (int s = first_slot; s < first_slot + count; s++) begin
            for (int r = 0; r < tpu_pkg::MUL_SIZE; r++) begin
                wt[s][r] = rand_vec();
            end
        end
    endtask

    task automatic push_instr(input int u, input int it, input int vc, input int slot);
        tpu_pkg::decoded_instr_t d;
        d.mac_op    = 2'b10;
        d.u_dim     = tpu_pkg::dim_t'(u);
        d.iter_dim  = tpu_pkg::dim_t'(it);
        d.vec_count = tpu_pkg::vcnt_t'(vc);
        ins_vcnt[ins_n]  = vc;
        ins_tiles[ins_n] = (u / tpu_pkg::MUL_SIZE) * (it / tpu_pkg::MUL_SIZE);
        ins_base[ins_n]  = slot;
        ins_n++;
        @(negedge clk_i);
        while (instr_full_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        instr_push_i <= 1'b1;
        instr_i      <= d;
        @(posedge clk_i);
        instr_push_i <= 1'b0;
    endtask

    // one row every gap+2 cycles so full is seen after the previous push landed
    task automatic push_rows(input int first, input int count, input int gap);
        for (int g = first; g < first + count; g++) begin
            @(negedge clk_i);
            while (weight_full_o) begin
                @(negedge clk_i);
            end
            @(posedge clk_i);
            weight_push_i <= 1'b1;
            weight_row_i  <= wt[g / tpu_pkg::MUL_SIZE][g % tpu_pkg::MUL_SIZE];
            rows_pushed++;
            @(posedge clk_i);
            weight_push_i <= 1'b0;
            repeat (gap) @(posedge clk_i);
        end
    endtask

    task automatic drive_acts(input int count);
        tpu_pkg::vec_t v;
        int            sent;
        sent = 0;
        v    = rand_vec();
        while (sent < count) begin
            @(posedge clk_i);
            if (act_valid_i && compute_rdy_o) begin
                sent++;
                v = rand_vec();
            end
            if (sent < count && compute_rdy_o) begin
                act_valid_i <= 1'b1;
                act_i       <= v;   // held until accepted
            end else begin
                act_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (3) @(negedge clk_i);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    // acceptance fills the expected queue and res_valid_o drains it
    always @(posedge clk_i) begin : monitor
        tpu_pkg::result_t exp;
        int               acc_cyc;
        int               t;
        logic             is_idle;
        if (res_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("result arrived with no activation outstanding");
                errors++;
            end else begin
                exp     = exp_q.pop_front();
                acc_cyc = acc_cyc_q.pop_front();
                compare_value("res_o.tile", 32'(res_o.tile), 32'(exp.tile));
                for (int k = 0; k < tpu_pkg::MUL_SIZE; k++) begin
                    compare_value($sformatf("res_o.sums[%0d]", k), {12'h0, res_o.sums[k]},
                                  {12'h0, exp.sums[k]});
                end
                compare_value("res_valid_o latency", cycle - acc_cyc, 2);
            end
        end
        if (act_valid_i && compute_rdy_o) begin
            if (cur_ins >= ins_n) begin
                $display("activation accepted with no instruction outstanding");
                errors++;
            end else begin
                t   = cur_acc / ins_vcnt[cur_ins];   // tile in use for this vector
                exp = ref_result(tpu_pkg::tile_idx_t'(t), wt[ins_base[cur_ins] + t], act_i);
                exp_q.push_back(exp);
                acc_cyc_q.push_back(cycle);
                cur_acc++;
                if (cur_acc == ins_vcnt[cur_ins] * ins_tiles[cur_ins]) begin
                    cur_ins++;
                    cur_acc = 0;
                end
            end
        end
        if (weights_buffered_o) begin
            saw_buffered = 1'b1;
        end
        is_idle = (dut0.wcu0.state_q == 2'd0);
        if (is_idle && !idle_d) begin
            idle_entries++;
        end
        idle_d = is_idle;
    end

    initial begin : main
        int   err_before;
        int   rows_before;
        logic quiet;
        rst_i         = 1'b1;
        instr_push_i  = 1'b0;
        instr_i       = '0;
        weight_push_i = 1'b0;
        weight_row_i  = '0;
        act_valid_i   = 1'b0;
        act_i         = '0;
        rng_state     = 32'd85;
        ins_n         = 0;
        cur_ins       = 0;
        cur_acc       = 0;
        checks        = 0;
        errors        = 0;
        rows_pushed   = 0;
        idle_entries  = 0;
        idle_d        = 1'b1;
        saw_buffered  = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;

        // instruction and seven rows only so nothing may start
        err_before = errors;
        @(negedge clk_i);
        compare_value("compute_rdy_o", compute_rdy_o, 0);
        compare_value("weights_buffered_o", weights_buffered_o, 0);
        compare_value("res_valid_o", res_valid_o, 0);
        compare_value("instr_full_o", instr_full_o, 0);
        compare_value("weight_full_o", weight_full_o, 0);
        fill_tiles(0, 1);
        push_instr(8, 8, 3, 0);
        push_rows(0, 7, 0);
        quiet = 1'b0;
        repeat (20) begin
            @(negedge clk_i);
            quiet = quiet | compute_rdy_o | weights_buffered_o | res_valid_o;
        end
        compare_value("compute_rdy_o|weights_buffered_o|res_valid_o", quiet, 0);
        report_test(1, "idle before a full tile", err_before);

        err_before = errors;
        fork
            push_rows(7, 1, 0);
            drive_acts(3);
        join
        wait_results();
        report_test(2, "single tile", err_before);

        // 32x8 gives four tiles and the first tile waits in the FIFO
        err_before = errors;
        fill_tiles(1, 4);
        push_rows(8, 8, 0);
        @(negedge clk_i);
        compare_value("weight_full_o", weight_full_o, 1);
        saw_buffered = 1'b0;
        fork
            push_rows(16, 24, 0);
            begin
                push_instr(32, 8, 12, 1);
                drive_acts(48);
            end
        join
        wait_results();
        compare_value("weights_buffered_o seen high", saw_buffered, 1);
        report_test(3, "four tiles double buffered", err_before);

        err_before = errors;
        fill_tiles(5, 2);
        rows_before = rows_pushed;
        push_instr(16, 8, 3, 5);
        fork
            push_rows(40, 16, 3);
            begin
                @(negedge clk_i);
                while (!compute_rdy_o) begin
                    @(negedge clk_i);
                end
                compare_value("rows pushed before compute_rdy_o",
                              (rows_pushed - rows_before) >= tpu_pkg::MUL_SIZE, 1);
                drive_acts(6);
            end
        join
        wait_results();
        report_test(4, "slow weight rows", err_before);

        err_before   = errors;
        fill_tiles(7, 3);
        idle_entries = 0;
        push_instr(16, 8, 2, 7);
        push_instr(8, 8, 3, 9);
        fork
            push_rows(56, 24, 0);
            drive_acts(7);
        join
        wait_results();
        compare_value("compute_rdy_o", compute_rdy_o, 0);
        compare_value("weights_buffered_o", weights_buffered_o, 0);
        compare_value("returns to RESET state", idle_entries, 1);
        report_test(5, "back to back instructions", err_before);

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
tpu_pkg.sv
instr_queue.sv
weight_fifo.sv
weight_control_unit.sv
pe_row.sv
result_collector.sv
tpu_weight_top.sv
tb_tpu_weight.sv

// File: Bender.yml
package:
  name: tpu_weight

sources:
  - tpu_pkg.sv
  - instr_queue.sv
  - weight_fifo.sv
  - weight_control_unit.sv
  - pe_row.sv
  - result_collector.sv
  - tpu_weight_top.sv
  - target: simulation
    files:
      - tb_tpu_weight.sv
